/* source/cdc_pkg.sv */
package cdc_pkg;

  // one payload word as it travels through a channel
  typedef logic [15:0] data_t;

  // channel index, so at most four channels
  typedef logic [1:0] ch_t;

  // read port data word
  typedef logic [31:0] wb_word_t;

  // read side sequencing
  typedef enum logic [1:0] {
    st_idle,
    st_fetch,
    st_respond
  } rd_state_t;

  // pop result layout
  localparam int POP_VALID_BIT = 31;

  // status result layout, one bit per channel in each field
  localparam int STAT_EMPTY_LSB  = 0;
  localparam int STAT_FULL_LSB   = 4;
  localparam int STAT_AFULL_LSB  = 8;
  localparam int STAT_AEMPTY_LSB = 12;

endpackage

/* source/dual_port_ram.sv */
module dual_port_ram
  import cdc_pkg::*;
#(
  parameter int ADDR_WIDTH = 3
) (
  input  logic                  wr_clk,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  data_t                 wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output data_t                 rd_data
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  data_t mem [DEPTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // output register, loaded only on a read
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* source/async_fifo.sv */
module async_fifo
  import cdc_pkg::*;
#(
  parameter int FIFO_DEPTH  = 8,
  parameter int FIFO_AFULL  = FIFO_DEPTH - 2,
  parameter int FIFO_AEMPTY = 1
) (
  input  logic  wr_clk,
  input  logic  wr_rst_n,
  input  logic  wr_en,
  input  data_t wr_data,
  output logic  full,
  output logic  afull,
  input  logic  rd_clk,
  input  logic  rd_rst_n,
  input  logic  rd_en,
  output data_t rd_data,
  output logic  empty,
  output logic  aempty
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  // pointers carry one wrap bit above the address
  typedef logic [ADDR_WIDTH:0] ptr_t;

  function automatic ptr_t gray2bin(input ptr_t g);
    ptr_t b;
    b[ADDR_WIDTH] = g[ADDR_WIDTH];
    for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  logic wr_vld;
  logic rd_vld;

  ptr_t wr_bin;
  ptr_t wr_bin_nxt;
  ptr_t wr_gray;
  ptr_t wr_gray_nxt;
  ptr_t wr_gray_r1;
  ptr_t wr_gray_r2;
  ptr_t wr_bin_r;

  ptr_t rd_bin;
  ptr_t rd_bin_nxt;
  ptr_t rd_gray;
  ptr_t rd_gray_nxt;
  ptr_t rd_gray_w1;
  ptr_t rd_gray_w2;
  ptr_t rd_bin_w;

  ptr_t wr_used;
  ptr_t rd_left;

  assign wr_vld = wr_en && !full;
  assign rd_vld = rd_en && !empty;

  dual_port_ram #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_ram (
    .wr_clk  (wr_clk),
    .wr_en   (wr_vld),
    .wr_addr (wr_bin[ADDR_WIDTH-1:0]),
    .wr_data (wr_data),
    .rd_clk  (rd_clk),
    .rd_en   (rd_vld),
    .rd_addr (rd_bin[ADDR_WIDTH-1:0]),
    .rd_data (rd_data)
  );

  assign wr_bin_nxt  = wr_bin + ptr_t'(wr_vld);
  assign wr_gray_nxt = wr_bin_nxt ^ (wr_bin_nxt >> 1);
  assign rd_bin_w    = gray2bin(rd_gray_w2);
  assign wr_used     = wr_bin_nxt - rd_bin_w;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_w1 <= '0;
      rd_gray_w2 <= '0;
      full       <= 1'b0;
      afull      <= 1'b0;
    end else begin
      wr_bin     <= wr_bin_nxt;
      wr_gray    <= wr_gray_nxt;
      rd_gray_w1 <= rd_gray;
      rd_gray_w2 <= rd_gray_w1;
      full       <= (wr_used == ptr_t'(FIFO_DEPTH));
      afull      <= (wr_used >= ptr_t'(FIFO_AFULL));
    end
  end

  assign rd_bin_nxt  = rd_bin + ptr_t'(rd_vld);
  assign rd_gray_nxt = rd_bin_nxt ^ (rd_bin_nxt >> 1);
  assign wr_bin_r    = gray2bin(wr_gray_r2);
  assign rd_left     = wr_bin_r - rd_bin_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_r1 <= '0;
      wr_gray_r2 <= '0;
      empty      <= 1'b1;
      aempty     <= 1'b1;
    end else begin
      rd_bin     <= rd_bin_nxt;
      rd_gray    <= rd_gray_nxt;
      wr_gray_r1 <= wr_gray;
      wr_gray_r2 <= wr_gray_r1;
      empty      <= (rd_left == '0);
      aempty     <= (rd_left <= ptr_t'(FIFO_AEMPTY));
    end
  end

endmodule

/* source/wb_wr_demux.sv */
module wb_wr_demux
  import cdc_pkg::*;
#(
  parameter int NUM_CH = 4
) (
  input  logic              wr_clk,
  input  logic              wr_rst_n,
  input  logic              wr_cyc,
  input  logic              wr_stb,
  input  logic              wr_we,
  input  logic [3:0]        wr_adr,
  input  data_t             wr_dat,
  output logic              wr_ack,
  input  logic [NUM_CH-1:0] full,
  output logic [NUM_CH-1:0] push,
  output data_t             push_data
);

  ch_t  ch;
  logic hit;
  logic req;
  logic room;

  // a request already acked is not taken twice
  assign req = wr_cyc && wr_stb && wr_we && !wr_ack;

  assign ch  = wr_adr[$bits(ch_t)-1:0];
  assign hit = (wr_adr < 4'(NUM_CH));

  // missing channels always have room, the word is just dropped
  assign room = !hit || !full[ch];

  always_comb begin
    push = '0;
    if (req && hit && room) begin
      push[ch] = 1'b1;
    end
  end

  assign push_data = wr_dat;

  // ack rises on the same edge that stores the word
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ack <= 1'b0;
    end else begin
      wr_ack <= req && room;
    end
  end

endmodule

/* source/wb_rd_arbiter.sv */
module wb_rd_arbiter
  import cdc_pkg::*;
#(
  parameter int NUM_CH = 4
) (
  input  logic                            rd_clk,
  input  logic                            rd_rst_n,
  input  logic                            rd_cyc,
  input  logic                            rd_stb,
  input  logic                            rd_we,
  input  logic                            rd_adr,
  output logic                            rd_ack,
  output wb_word_t                        rd_dat,
  input  logic [NUM_CH-1:0]               empty,
  input  logic [NUM_CH-1:0]               full,
  input  logic [NUM_CH-1:0]               afull,
  input  logic [NUM_CH-1:0]               aempty,
  output logic [NUM_CH-1:0]               pop,
  input  logic [NUM_CH*$bits(data_t)-1:0] pop_data
);

  rd_state_t state;
  ch_t       last_ch;
  ch_t       sel_ch;
  ch_t       cur_ch;
  logic      sel_found;
  logic      req;
  logic      pop_req;
  data_t     cur_data;
  wb_word_t  status_word;
  wb_word_t  pop_word;

  logic [NUM_CH-1:0] full_s1;
  logic [NUM_CH-1:0] full_s2;
  logic [NUM_CH-1:0] afull_s1;
  logic [NUM_CH-1:0] afull_s2;

  assign req     = rd_cyc && rd_stb && !rd_ack;
  assign pop_req = req && !rd_we && !rd_adr;

  // first non-empty channel after the one served last
  always_comb begin
    int unsigned idx;
    sel_found = 1'b0;
    sel_ch    = last_ch;
    for (int i = 1; i <= NUM_CH; i++) begin
      idx = (int'(last_ch) + i) % NUM_CH;
      if (!sel_found && !empty[idx]) begin
        sel_found = 1'b1;
        sel_ch    = ch_t'(idx);
      end
    end
  end

  // full flags come from the write clock
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      full_s1  <= '0;
      full_s2  <= '0;
      afull_s1 <= '0;
      afull_s2 <= '0;
    end else begin
      full_s1  <= full;
      full_s2  <= full_s1;
      afull_s1 <= afull;
      afull_s2 <= afull_s1;
    end
  end

  always_comb begin
    status_word = '0;
    for (int i = 0; i < NUM_CH; i++) begin
      status_word[STAT_EMPTY_LSB + i]  = empty[i];
      status_word[STAT_FULL_LSB + i]   = full_s2[i];
      status_word[STAT_AFULL_LSB + i]  = afull_s2[i];
      status_word[STAT_AEMPTY_LSB + i] = aempty[i];
    end
  end

  assign cur_data = pop_data[int'(cur_ch)*$bits(data_t) +: $bits(data_t)];

  always_comb begin
    pop_word = '0;
    pop_word[POP_VALID_BIT] = 1'b1;
    pop_word[$bits(data_t) +: $bits(ch_t)] = cur_ch;
    pop_word[$bits(data_t)-1:0] = cur_data;
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      state   <= st_idle;
      last_ch <= ch_t'(NUM_CH - 1);
      pop     <= '0;
      rd_ack  <= 1'b0;
    end else begin
      pop    <= '0;
      rd_ack <= 1'b0;
      case (state)
        st_idle: begin
          if (pop_req && sel_found) begin
            pop[sel_ch] <= 1'b1;
            state       <= st_fetch;
          end else if (req) begin
            rd_ack <= 1'b1;
          end
        end
        // ram output register loads during this cycle
        st_fetch: state <= st_respond;
        st_respond: begin
          rd_ack  <= 1'b1;
          last_ch <= cur_ch;
          state   <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge rd_clk) begin
    if (state == st_idle && pop_req && sel_found) begin
      cur_ch <= sel_ch;
    end
    if (state == st_respond) begin
      rd_dat <= pop_word;
    end else if (state == st_idle && req) begin
      // empty pop and bus writes return a clear word
      rd_dat <= (!rd_we && rd_adr) ? status_word : '0;
    end
  end

endmodule

/* source/fifo_bank_top.sv */
module fifo_bank_top
  import cdc_pkg::*;
#(
  parameter int NUM_CH      = 4,
  parameter int FIFO_DEPTH  = 8,
  parameter int FIFO_AFULL  = FIFO_DEPTH - 2,
  parameter int FIFO_AEMPTY = 1
) (
  input  logic       wr_clk,
  input  logic       wr_rst_n,
  input  logic       wr_cyc,
  input  logic       wr_stb,
  input  logic       wr_we,
  input  logic [3:0] wr_adr,
  input  data_t      wr_dat,
  output logic       wr_ack,
  input  logic       rd_clk,
  input  logic       rd_rst_n,
  input  logic       rd_cyc,
  input  logic       rd_stb,
  input  logic       rd_we,
  input  logic       rd_adr,
  output logic       rd_ack,
  output wb_word_t   rd_dat
);

  logic [NUM_CH-1:0] full;
  logic [NUM_CH-1:0] afull;
  logic [NUM_CH-1:0] empty;
  logic [NUM_CH-1:0] aempty;
  logic [NUM_CH-1:0] push;
  logic [NUM_CH-1:0] pop;
  data_t             push_data;

  logic [NUM_CH*$bits(data_t)-1:0] pop_data;

  wb_wr_demux #(
    .NUM_CH (NUM_CH)
  ) u_wr_demux (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_cyc    (wr_cyc),
    .wr_stb    (wr_stb),
    .wr_we     (wr_we),
    .wr_adr    (wr_adr),
    .wr_dat    (wr_dat),
    .wr_ack    (wr_ack),
    .full      (full),
    .push      (push),
    .push_data (push_data)
  );

  // one fifo per channel
  for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
    async_fifo #(
      .FIFO_DEPTH  (FIFO_DEPTH),
      .FIFO_AFULL  (FIFO_AFULL),
      .FIFO_AEMPTY (FIFO_AEMPTY)
    ) u_fifo (
      .wr_clk   (wr_clk),
      .wr_rst_n (wr_rst_n),
      .wr_en    (push[i]),
      .wr_data  (push_data),
      .full     (full[i]),
      .afull    (afull[i]),
      .rd_clk   (rd_clk),
      .rd_rst_n (rd_rst_n),
      .rd_en    (pop[i]),
      .rd_data  (pop_data[i*$bits(data_t) +: $bits(data_t)]),
      .empty    (empty[i]),
      .aempty   (aempty[i])
    );
  end

  wb_rd_arbiter #(
    .NUM_CH (NUM_CH)
  ) u_rd_arbiter (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_cyc   (rd_cyc),
    .rd_stb   (rd_stb),
    .rd_we    (rd_we),
    .rd_adr   (rd_adr),
    .rd_ack   (rd_ack),
    .rd_dat   (rd_dat),
    .empty    (empty),
    .full     (full),
    .afull    (afull),
    .aempty   (aempty),
    .pop      (pop),
    .pop_data (pop_data)
  );

endmodule

/* test/fifo_bank_sva.sv */
module fifo_bank_sva
  import cdc_pkg::*;
#(
  parameter int NUM_CH = 4
) (
  input logic              wr_clk,
  input logic              wr_rst_n,
  input logic              wr_cyc,
  input logic              wr_stb,
  input logic              wr_we,
  input logic [3:0]        wr_adr,
  input logic              wr_ack,
  input logic [NUM_CH-1:0] full,
  input logic              rd_clk,
  input logic              rd_rst_n,
  input logic              rd_cyc,
  input logic              rd_stb,
  input logic              rd_ack,
  input wb_word_t          rd_dat,
  input logic [NUM_CH-1:0] empty
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;
  logic        wr_req_full;

  // pending write whose target channel is full
  assign wr_req_full = wr_cyc && wr_stb && wr_we && !wr_ack &&
                       (wr_adr < 4'(NUM_CH)) && full[wr_adr[1:0]];

  wr_ack_req: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    !(wr_cyc && wr_stb) |=> !wr_ack)
    else begin
      fail_count++;
      $error("write ack without cyc and stb");
    end

  rd_ack_req: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    !(rd_cyc && rd_stb) |=> !rd_ack)
    else begin
      fail_count++;
      $error("read ack without cyc and stb");
    end

  wr_ack_once: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    wr_ack |=> !wr_ack)
    else begin
      fail_count++;
      $error("write ack longer than one cycle");
    end

  rd_ack_once: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_ack |=> !rd_ack)
    else begin
      fail_count++;
      $error("read ack longer than one cycle");
    end

  no_ack_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    wr_req_full |=> !wr_ack)
    else begin
      fail_count++;
      $error("write acked while its channel was full");
    end

  // request was sampled three cycles before the ack
  pop_valid: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_ack && rd_dat[31] |-> $past(empty != '1, 3))
    else begin
      fail_count++;
      $error("valid pop result while all channels were empty");
    end

endmodule

bind fifo_bank_top fifo_bank_sva #(
  .NUM_CH (NUM_CH)
) u_sva (
  .wr_clk   (wr_clk),
  .wr_rst_n (wr_rst_n),
  .wr_cyc   (wr_cyc),
  .wr_stb   (wr_stb),
  .wr_we    (wr_we),
  .wr_adr   (wr_adr),
  .wr_ack   (wr_ack),
  .full     (full),
  .rd_clk   (rd_clk),
  .rd_rst_n (rd_rst_n),
  .rd_cyc   (rd_cyc),
  .rd_stb   (rd_stb),
  .rd_ack   (rd_ack),
  .rd_dat   (rd_dat),
  .empty    (empty)
);

/* test/tb_fifo_bank.sv */
module tb_fifo_bank
  import cdc_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_CH = 4;
  localparam int DEPTH  = 8;
  localparam int AFULL  = DEPTH - 2;
  localparam int AEMPTY = 1;
  localparam int LIMIT  = 40;

  logic       wr_clk = 1'b0;
  logic       rd_clk = 1'b0;
  logic       wr_rst_n;
  logic       rd_rst_n;
  logic       wr_cyc;
  logic       wr_stb;
  logic       wr_we;
  logic [3:0] wr_adr;
  data_t      wr_dat;
  logic       wr_ack;
  logic       rd_cyc;
  logic       rd_stb;
  logic       rd_we;
  logic       rd_adr;
  logic       rd_ack;
  wb_word_t   rd_dat;

  // reference contents of each channel
  data_t       model_q [NUM_CH][$];
  int          last_served;
  int          errors;
  int          test_errs;
  int          tests;
  int          failed;
  logic [31:0] seed;

  fifo_bank_top u_fifo_bank_top (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_cyc   (wr_cyc),
    .wr_stb   (wr_stb),
    .wr_we    (wr_we),
    .wr_adr   (wr_adr),
    .wr_dat   (wr_dat),
    .wr_ack   (wr_ack),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_cyc   (rd_cyc),
    .rd_stb   (rd_stb),
    .rd_we    (rd_we),
    .rd_adr   (rd_adr),
    .rd_ack   (rd_ack),
    .rd_dat   (rd_dat)
  );

  // the two clocks share no common period
  always #50 rd_clk = ~rd_clk;
  always #35 wr_clk = ~wr_clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // status word implied by the model counts
  function automatic wb_word_t model_status();
    wb_word_t w;
    int       n;
    w = '0;
    for (int i = 0; i < NUM_CH; i++) begin
      n = model_q[i].size();
      w[i]      = (n == 0);
      w[4 + i]  = (n == DEPTH);
      w[8 + i]  = (n >= AFULL);
      w[12 + i] = (n <= AEMPTY);
    end
    return w;
  endfunction

  // next non-empty channel after the last one served, -1 when all are empty
  function automatic int next_channel();
    int idx;
    for (int i = 1; i <= NUM_CH; i++) begin
      idx = (last_served + i) % NUM_CH;
      if (model_q[idx].size() != 0) begin
        return idx;
      end
    end
    return -1;
  endfunction

  task automatic check_word(input string name, input wb_word_t exp, input wb_word_t act);
    assert (act === exp) else begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("%s: no ack came within %0d cycles", what, LIMIT);
    errors++;
  endtask

  task automatic write_start(input int ch, input data_t data);
    @(negedge wr_clk);
    wr_cyc = 1'b1;
    wr_stb = 1'b1;
    wr_we  = 1'b1;
    wr_adr = 4'(ch);
    wr_dat = data;
  endtask

  task automatic write_wait(input int limit, output bit acked);
    acked = 1'b0;
    for (int i = 0; i < limit && !acked; i++) begin
      @(negedge wr_clk);
      if (wr_ack) begin
        acked  = 1'b1;
        wr_cyc = 1'b0;
        wr_stb = 1'b0;
      end
    end
  endtask

  task automatic write_word(input string name, input int ch, input data_t data);
    bit acked;
    write_start(ch, data);
    write_wait(LIMIT, acked);
    if (acked) begin
      model_q[ch].push_back(data);
    end else begin
      report_timeout({name, " write"});
      wr_cyc = 1'b0;
      wr_stb = 1'b0;
    end
  endtask

  task automatic fill_channel(input string name, input int ch, input int count);
    for (int i = 0; i < count; i++) begin
      seed = xorshift(seed);
      write_word(name, ch, seed[15:0]);
    end
  endtask

  task automatic read_bus(input string name, input logic adr, output wb_word_t word);
    bit acked;
    acked = 1'b0;
    word  = '0;
    @(negedge rd_clk);
    rd_cyc = 1'b1;
    rd_stb = 1'b1;
    rd_adr = adr;
    for (int i = 0; i < LIMIT && !acked; i++) begin
      @(negedge rd_clk);
      if (rd_ack) begin
        acked = 1'b1;
        word  = rd_dat;
      end
    end
    rd_cyc = 1'b0;
    rd_stb = 1'b0;
    if (!acked) begin
      report_timeout({name, " read"});
    end
  endtask

  task automatic pop_check(input string name);
    wb_word_t word;
    data_t    head;
    int       ch;
    ch = next_channel();
    read_bus(name, 1'b0, word);
    if (ch < 0) begin
      check_word(name, 32'h0, word & 32'h8000_0000);
    end else begin
      head = model_q[ch].pop_front();
      last_served = ch;
      check_word(name, {1'b1, 13'h0, 2'(ch), head}, word);
    end
  endtask

  // polls until the flags have crossed both domains
  task automatic wait_status(input string name);
    wb_word_t word;
    wb_word_t exp;
    bit       match;
    exp   = model_status();
    match = 1'b0;
    word  = '0;
    for (int i = 0; i < LIMIT && !match; i++) begin
      read_bus(name, 1'b1, word);
      match = (word == exp);
    end
    check_word(name, exp, word);
  endtask

  task automatic drain(input string name);
    int n;
    wait_status(name);
    n = 0;
    for (int i = 0; i < NUM_CH; i++) begin
      n += model_q[i].size();
    end
    repeat (n) pop_check(name);
  endtask

  task automatic begin_test();
    test_errs = errors;
    tests++;
  endtask

  task automatic end_test(input string name);
    if (errors == test_errs) begin
      $display("test %s: passed", name);
    end else begin
      failed++;
      $display("test %s: failed with %0d errors", name, errors - test_errs);
    end
  endtask

  initial begin
    wb_word_t word;
    data_t    held;
    bit       acked;
    int       ch;
    int       sva_fails;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_cyc   = 1'b0;
    wr_stb   = 1'b0;
    wr_we    = 1'b0;
    wr_adr   = '0;
    wr_dat   = '0;
    rd_cyc   = 1'b0;
    rd_stb   = 1'b0;
    rd_we    = 1'b0;
    rd_adr   = 1'b0;
    seed     = 32'h711c;
    errors   = 0;
    tests    = 0;
    failed   = 0;
    last_served = NUM_CH - 1;
    repeat (3) @(posedge rd_clk);
    @(negedge rd_clk);
    rd_rst_n = 1'b1;
    @(negedge wr_clk);
    wr_rst_n = 1'b1;

    begin_test();
    check_word("reset", 32'h0, {30'h0, wr_ack, rd_ack});
    read_bus("reset", 1'b1, word);
    check_word("reset", model_status(), word);
    end_test("reset");

    begin_test();
    for (int i = 0; i < 16; i++) begin
      seed = xorshift(seed);
      ch = int'(seed[17:16]);
      while (model_q[ch].size() == DEPTH) begin
        ch = (ch + 1) % NUM_CH;
      end
      write_word("order", ch, seed[15:0]);
    end
    drain("order");
    end_test("order");

    begin_test();
    for (int c = 0; c < NUM_CH; c++) begin
      fill_channel("round_robin", c, 2);
    end
    wait_status("round_robin");
    repeat (NUM_CH + 1) pop_check("round_robin");
    drain("round_robin");
    end_test("round_robin");

    begin_test();
    fill_channel("backpressure", 1, DEPTH);
    wait_status("backpressure");
    seed = xorshift(seed);
    held = seed[15:0];
    write_start(1, held);
    write_wait(LIMIT, acked);
    assert (!acked) else begin
      $display("backpressure: a write to a full channel was acked");
      errors++;
    end
    if (!acked) begin
      // the pop frees a slot while the write is still pending
      fork
        write_wait(LIMIT, acked);
        pop_check("backpressure");
      join
      if (acked) begin
        model_q[1].push_back(held);
      end else begin
        report_timeout("backpressure held write");
        wr_cyc = 1'b0;
        wr_stb = 1'b0;
      end
    end
    drain("backpressure");
    end_test("backpressure");

    begin_test();
    wait_status("empty_pop");
    pop_check("empty_pop");
    end_test("empty_pop");

    begin_test();
    fill_channel("flags", 2, AFULL);
    fill_channel("flags", 1, AFULL - 1);
    fill_channel("flags", 0, AEMPTY + 1);
    fill_channel("flags", 3, AEMPTY);
    wait_status("flags");
    drain("flags");
    end_test("flags");

    sva_fails = int'(u_fifo_bank_top.u_sva.fail_count);
    $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
             tests, failed, errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* all.f */
source/cdc_pkg.sv
source/dual_port_ram.sv
source/async_fifo.sv
source/wb_wr_demux.sv
source/wb_rd_arbiter.sv
source/fifo_bank_top.sv
test/fifo_bank_sva.sv
test/tb_fifo_bank.sv

/* Makefile */
SIM = obj_dir/Vtb_fifo_bank

.PHONY: run clean

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -q "Done: no errors" sim.log

$(SIM): all.f $(shell cat all.f)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module tb_fifo_bank -f all.f

clean:
	rm -rf obj_dir sim.log
